/* Makefile */
TOOL      = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_engine_cu_setup
FILE_LIST = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = FAIL: see errors above

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG) || [ $$status -ne 0 ]; then \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* flist.f */
hw/cu_setup_pkg.sv
hw/stride_counter.sv
hw/setup_sequencer.sv
hw/request_builder.sv
hw/request_fifo.sv
hw/engine_cu_setup.sv
tb/engine_cu_setup_props.sv
tb/tb_engine_cu_setup.sv

/* hw/cu_setup_pkg.sv */
// --------------------
// Shared definitions for the CU setup engine
//   Address and count widths, shift width
//   Request FIFO depth and threshold
//   Cache geometry for flush interleave
//   Sequencer state encoding
// --------------------

package cu_setup_pkg;

    // Datapath widths
    localparam int ADDR_W  = 32;
    localparam int COUNT_W = 32;
    localparam int SHIFT_W = 5;

    // --------------------
    // Request FIFO
    // --------------------
    localparam int FIFO_DEPTH       = 16;
    localparam int FIFO_PROG_THRESH = 8;
    localparam int FIFO_PTR_W       = $clog2(FIFO_DEPTH);
    // One extra bit so a full FIFO is distinct from an empty one
    localparam int FIFO_COUNT_W     = FIFO_PTR_W + 1;

    // --------------------
    // Cache geometry
    // --------------------
    localparam int CACHE_NUM_WAYS = 4;
    localparam int CACHE_WAYS_LOG = 2;
    // 64 byte lines
    localparam int CACHE_LINE_LOG = 6;

    // --------------------
    // Sequencer states
    // --------------------
    localparam int SEQ_W = 3;

    localparam logic [SEQ_W-1:0] SEQ_RESET = 3'd0;
    localparam logic [SEQ_W-1:0] SEQ_IDLE  = 3'd1;
    localparam logic [SEQ_W-1:0] SEQ_SETUP = 3'd2;
    localparam logic [SEQ_W-1:0] SEQ_BUSY  = 3'd3;
    localparam logic [SEQ_W-1:0] SEQ_PAUSE = 3'd4;
    localparam logic [SEQ_W-1:0] SEQ_DONE  = 3'd5;

endpackage

/* hw/engine_cu_setup.sv */
// --------------------
// CU setup engine top level
//   Input and configuration registers
//   Counter, sequencer, builder, request FIFO
// --------------------

`timescale 1ns/100ps

module engine_cu_setup (
    input  logic                             ap_clk,
    input  logic                             areset_engine,
    input  logic                             start,
    input  logic                             cfg_valid,
    input  logic [ cu_setup_pkg::ADDR_W-1:0] cfg_array_pointer,
    input  logic [cu_setup_pkg::COUNT_W-1:0] cfg_start_read,
    input  logic [cu_setup_pkg::COUNT_W-1:0] cfg_end_read,
    input  logic [cu_setup_pkg::COUNT_W-1:0] cfg_stride,
    input  logic                             cfg_shift_dir,
    input  logic [cu_setup_pkg::SHIFT_W-1:0] cfg_shift_amount,
    input  logic                             cfg_flush_mode,
    input  logic                             request_pop,
    output logic                             request_valid,
    output logic [ cu_setup_pkg::ADDR_W-1:0] request_base,
    output logic [ cu_setup_pkg::ADDR_W-1:0] request_offset,
    output logic [cu_setup_pkg::COUNT_W-1:0] request_data,
    output logic                             ready,
    output logic                             done
);

    logic start_q;
    logic cfg_valid_q;

    logic [ cu_setup_pkg::ADDR_W-1:0] array_pointer_q;
    logic [cu_setup_pkg::COUNT_W-1:0] start_read_q;
    logic [cu_setup_pkg::COUNT_W-1:0] end_read_q;
    logic [cu_setup_pkg::COUNT_W-1:0] stride_q;
    logic                             shift_dir_q;
    logic [cu_setup_pkg::SHIFT_W-1:0] shift_amount_q;
    logic                             flush_mode_q;

    logic [cu_setup_pkg::COUNT_W-1:0] count;
    logic                             load;
    logic                             issue;
    logic                             push;
    logic [ cu_setup_pkg::ADDR_W-1:0] push_offset;
    logic [cu_setup_pkg::COUNT_W-1:0] push_data;
    logic                             fifo_empty;
    logic                             fifo_prog_full;

    // --------------------
    // Input registers
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            start_q     <= 1'b0;
            cfg_valid_q <= 1'b0;
        end
        else begin
            start_q     <= start;
            cfg_valid_q <= cfg_valid;
        end
    end

    // Configuration held steady for the whole run
    always_ff @(posedge ap_clk) begin
        if (cfg_valid) begin
            array_pointer_q <= cfg_array_pointer;
            start_read_q    <= cfg_start_read;
            end_read_q      <= cfg_end_read;
            stride_q        <= cfg_stride;
            shift_dir_q     <= cfg_shift_dir;
            shift_amount_q  <= cfg_shift_amount;
            flush_mode_q    <= cfg_flush_mode;
        end
    end

    // --------------------
    // Datapath
    // --------------------
    stride_counter inst_counter (
        .ap_clk       (ap_clk),
        .areset_engine(areset_engine),
        .load         (load),
        .advance      (issue),
        .load_value   (start_read_q),
        .stride       (stride_q),
        .count        (count)
    );

    setup_sequencer inst_sequencer (
        .ap_clk       (ap_clk),
        .areset_engine(areset_engine),
        .start        (start_q),
        .cfg_valid    (cfg_valid_q),
        .end_read     (end_read_q),
        .count        (count),
        .prog_full    (fifo_prog_full),
        .fifo_empty   (fifo_empty),
        .ready        (ready),
        .done         (done),
        .load         (load),
        .issue        (issue)
    );

    request_builder inst_builder (
        .ap_clk       (ap_clk),
        .areset_engine(areset_engine),
        .issue        (issue),
        .count        (count),
        .shift_dir    (shift_dir_q),
        .shift_amount (shift_amount_q),
        .flush_mode   (flush_mode_q),
        .push         (push),
        .push_offset  (push_offset),
        .push_data    (push_data)
    );

    // Pop goes straight in so data appears the cycle after the strobe
    request_fifo inst_fifo (
        .ap_clk       (ap_clk),
        .areset_engine(areset_engine),
        .push         (push),
        .din_base     (array_pointer_q),
        .din_offset   (push_offset),
        .din_data     (push_data),
        .pop          (request_pop),
        .valid        (request_valid),
        .dout_base    (request_base),
        .dout_offset  (request_offset),
        .dout_data    (request_data),
        .empty        (fifo_empty),
        .prog_full    (fifo_prog_full)
    );

endmodule

/* hw/request_builder.sv */
// --------------------
// Request builder
//   Offset from count by shift or cache interleave
//   Registered push with offset and data
// --------------------

`timescale 1ns/100ps

module request_builder (
    input  logic                             ap_clk,
    input  logic                             areset_engine,
    input  logic                             issue,
    input  logic [cu_setup_pkg::COUNT_W-1:0] count,
    input  logic                             shift_dir,
    input  logic [cu_setup_pkg::SHIFT_W-1:0] shift_amount,
    input  logic                             flush_mode,
    output logic                             push,
    output logic [ cu_setup_pkg::ADDR_W-1:0] push_offset,
    output logic [cu_setup_pkg::COUNT_W-1:0] push_data
);

    logic [cu_setup_pkg::ADDR_W-1:0] count_addr;
    logic [cu_setup_pkg::ADDR_W-1:0] line_part;
    logic [cu_setup_pkg::ADDR_W-1:0] way_part;
    logic [cu_setup_pkg::ADDR_W-1:0] offset_comb;

    assign count_addr = cu_setup_pkg::ADDR_W'(count);

    // Consecutive counts walk the ways of one set in flush mode
    assign line_part = (count_addr >> cu_setup_pkg::CACHE_WAYS_LOG)
                       << (cu_setup_pkg::CACHE_LINE_LOG + cu_setup_pkg::CACHE_WAYS_LOG);
    assign way_part  = (count_addr & cu_setup_pkg::ADDR_W'(cu_setup_pkg::CACHE_NUM_WAYS - 1))
                       << cu_setup_pkg::CACHE_LINE_LOG;

    always_comb begin
        if (flush_mode) begin
            offset_comb = line_part | way_part;
        end
        else if (shift_dir) begin
            offset_comb = count_addr << shift_amount;
        end
        else begin
            offset_comb = count_addr >> shift_amount;
        end
    end

    // --------------------
    // Push stage
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            push <= 1'b0;
        end
        else begin
            push <= issue;
        end
    end

    always_ff @(posedge ap_clk) begin
        push_offset <= offset_comb;
        push_data   <= count;
    end

endmodule

/* hw/request_fifo.sv */
// --------------------
// Synchronous request FIFO
//   Circular buffer with occupancy count
//   Registered read data and valid
//   Empty and programmable full flags
// --------------------

`timescale 1ns/100ps

module request_fifo (
    input  logic                             ap_clk,
    input  logic                             areset_engine,
    input  logic                             push,
    input  logic [ cu_setup_pkg::ADDR_W-1:0] din_base,
    input  logic [ cu_setup_pkg::ADDR_W-1:0] din_offset,
    input  logic [cu_setup_pkg::COUNT_W-1:0] din_data,
    input  logic                             pop,
    output logic                             valid,
    output logic [ cu_setup_pkg::ADDR_W-1:0] dout_base,
    output logic [ cu_setup_pkg::ADDR_W-1:0] dout_offset,
    output logic [cu_setup_pkg::COUNT_W-1:0] dout_data,
    output logic                             empty,
    output logic                             prog_full
);

    logic [cu_setup_pkg::ADDR_W-1:0]  mem_base   [cu_setup_pkg::FIFO_DEPTH];
    logic [cu_setup_pkg::ADDR_W-1:0]  mem_offset [cu_setup_pkg::FIFO_DEPTH];
    logic [cu_setup_pkg::COUNT_W-1:0] mem_data   [cu_setup_pkg::FIFO_DEPTH];

    logic [cu_setup_pkg::FIFO_PTR_W-1:0]   wr_ptr;
    logic [cu_setup_pkg::FIFO_PTR_W-1:0]   rd_ptr;
    logic [cu_setup_pkg::FIFO_COUNT_W-1:0] occupancy;

    logic full;
    logic wr_en;
    logic rd_en;

    assign full      = (occupancy == cu_setup_pkg::FIFO_COUNT_W'(cu_setup_pkg::FIFO_DEPTH));
    assign empty     = (occupancy == '0);
    assign prog_full = (occupancy >=
                        cu_setup_pkg::FIFO_COUNT_W'(cu_setup_pkg::FIFO_PROG_THRESH));

    // A push into a full FIFO is dropped
    assign wr_en = push & ~full;
    assign rd_en = pop & ~empty;

    // --------------------
    // Pointers and occupancy
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
            valid     <= 1'b0;
        end
        else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
            valid <= rd_en;
        end
    end

    // --------------------
    // Storage and read port
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (wr_en) begin
            mem_base[wr_ptr]   <= din_base;
            mem_offset[wr_ptr] <= din_offset;
            mem_data[wr_ptr]   <= din_data;
        end
        if (rd_en) begin
            dout_base   <= mem_base[rd_ptr];
            dout_offset <= mem_offset[rd_ptr];
            dout_data   <= mem_data[rd_ptr];
        end
    end

endmodule

/* hw/setup_sequencer.sv */
// --------------------
// Setup sequencer FSM
//   Start handshake, counter load
//   Issue while below end of range
//   Pause on FIFO programmable full
//   Registered ready and done
// --------------------

`timescale 1ns/100ps

module setup_sequencer (
    input  logic                             ap_clk,
    input  logic                             areset_engine,
    input  logic                             start,
    input  logic                             cfg_valid,
    input  logic [cu_setup_pkg::COUNT_W-1:0] end_read,
    input  logic [cu_setup_pkg::COUNT_W-1:0] count,
    input  logic                             prog_full,
    input  logic                             fifo_empty,
    output logic                             ready,
    output logic                             done,
    output logic                             load,
    output logic                             issue
);

    logic [cu_setup_pkg::SEQ_W-1:0] state;
    logic [cu_setup_pkg::SEQ_W-1:0] state_next;

    logic in_range;
    logic run_req;

    assign in_range = (count < end_read);
    assign run_req  = start & cfg_valid;

    // --------------------
    // State register
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            state <= cu_setup_pkg::SEQ_RESET;
        end
        else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            cu_setup_pkg::SEQ_RESET: begin
                state_next = cu_setup_pkg::SEQ_IDLE;
            end
            cu_setup_pkg::SEQ_IDLE: begin
                if (run_req) begin
                    state_next = cu_setup_pkg::SEQ_SETUP;
                end
            end
            // Counter loads on the way out of setup
            cu_setup_pkg::SEQ_SETUP: begin
                state_next = cu_setup_pkg::SEQ_BUSY;
            end
            cu_setup_pkg::SEQ_BUSY: begin
                if (!in_range) begin
                    state_next = cu_setup_pkg::SEQ_DONE;
                end
                else if (prog_full) begin
                    state_next = cu_setup_pkg::SEQ_PAUSE;
                end
            end
            // Count is held here, so nothing is skipped on resume
            cu_setup_pkg::SEQ_PAUSE: begin
                if (!prog_full) begin
                    state_next = cu_setup_pkg::SEQ_BUSY;
                end
            end
            cu_setup_pkg::SEQ_DONE: begin
                // Wait for the host to drop the request
                if (!run_req) begin
                    state_next = cu_setup_pkg::SEQ_IDLE;
                end
            end
            default: begin
                state_next = cu_setup_pkg::SEQ_RESET;
            end
        endcase
    end

    // --------------------
    // Counter control
    // --------------------
    assign load = (state == cu_setup_pkg::SEQ_SETUP);

    // The same strobe issues one request and advances the counter
    assign issue = (state == cu_setup_pkg::SEQ_BUSY) & in_range & ~prog_full;

    // --------------------
    // Status outputs
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            ready <= 1'b0;
            done  <= 1'b0;
        end
        else begin
            ready <= (state == cu_setup_pkg::SEQ_IDLE);
            // All pushes have landed by the time the FSM sits in done
            done  <= ((state == cu_setup_pkg::SEQ_IDLE) |
                      (state == cu_setup_pkg::SEQ_DONE)) & fifo_empty;
        end
    end

endmodule

/* hw/stride_counter.sv */
// --------------------
// Loadable up-counter
//   Loads a start value, then steps by a stride
// --------------------

`timescale 1ns/100ps

module stride_counter (
    input  logic                             ap_clk,
    input  logic                             areset_engine,
    input  logic                             load,
    input  logic                             advance,
    input  logic [cu_setup_pkg::COUNT_W-1:0] load_value,
    input  logic [cu_setup_pkg::COUNT_W-1:0] stride,
    output logic [cu_setup_pkg::COUNT_W-1:0] count
);

    // Load takes priority over a step
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            count <= '0;
        end
        else if (load) begin
            count <= load_value;
        end
        else if (advance) begin
            count <= count + stride;
        end
    end

endmodule

/* tb/engine_cu_setup_props.sv */
// --------------------
// Concurrent assertions for the CU setup engine
//   Reset values, FIFO overflow, handshake rules
// --------------------

`timescale 1ns/100ps

module engine_cu_setup_props (
    input logic                           ap_clk,
    input logic                           areset_engine,
    input logic                           ready,
    input logic                           done,
    input logic                           request_valid,
    input logic                           request_pop,
    input logic                           push,
    input logic                           fifo_full,
    input logic [cu_setup_pkg::SEQ_W-1:0] seq_state
);

    // Registered status clears in the cycle after reset is seen
    assert property (@(posedge ap_clk) areset_engine |=>
                     (!ready && !done && !request_valid &&
                      seq_state == cu_setup_pkg::SEQ_RESET))
        else $error("outputs or sequencer state not cleared after reset");

    assert property (@(posedge ap_clk) disable iff (areset_engine) push |-> !fifo_full)
        else $error("request FIFO pushed while full");

    assert property (@(posedge ap_clk) disable iff (areset_engine) !(ready && request_valid))
        else $error("ready and request_valid high together");

    // Read data follows the pop strobe by one cycle
    assert property (@(posedge ap_clk) disable iff (areset_engine)
                     request_valid |-> $past(request_pop))
        else $error("request_valid without a pop in the cycle before");

endmodule

bind engine_cu_setup engine_cu_setup_props i_props (
    .ap_clk       (ap_clk),
    .areset_engine(areset_engine),
    .ready        (ready),
    .done         (done),
    .request_valid(request_valid),
    .request_pop  (request_pop),
    .push         (push),
    .fifo_full    (inst_fifo.full),
    .seq_state    (inst_sequencer.state)
);

/* tb/tb_engine_cu_setup.sv */
// --------------------
// Testbench for the CU setup engine
//   Clock, reset and falling-edge stimulus
//   Reference model for counts and offsets
//   Directed tests and error counts
// --------------------

`timescale 1ns/100ps

module tb_engine_cu_setup;

    localparam int TIMEOUT_CYCLES = 3000;
    localparam int READY_TIMEOUT  = 20;
    localparam int START_LATENCY  = 5;

    logic                             ap_clk;
    logic                             areset_engine;
    logic                             start;
    logic                             cfg_valid;
    logic [ cu_setup_pkg::ADDR_W-1:0] cfg_array_pointer;
    logic [cu_setup_pkg::COUNT_W-1:0] cfg_start_read;
    logic [cu_setup_pkg::COUNT_W-1:0] cfg_end_read;
    logic [cu_setup_pkg::COUNT_W-1:0] cfg_stride;
    logic                             cfg_shift_dir;
    logic [cu_setup_pkg::SHIFT_W-1:0] cfg_shift_amount;
    logic                             cfg_flush_mode;
    logic                             request_pop;
    logic                             request_valid;
    logic [ cu_setup_pkg::ADDR_W-1:0] request_base;
    logic [ cu_setup_pkg::ADDR_W-1:0] request_offset;
    logic [cu_setup_pkg::COUNT_W-1:0] request_data;
    logic                             ready;
    logic                             done;

    int          error_count;
    int          check_count;
    logic [31:0] rng_state;

    engine_cu_setup i_engine_cu_setup (.*);

    always #10 ap_clk = ~ap_clk;

    function automatic logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Cache interleave in flush mode, else a plain shift
    function automatic logic [31:0] expected_offset(input logic [31:0] count,
                                                    input logic flush, input logic dir,
                                                    input logic [4:0] amount);
        if (flush) begin
            return ((count / 4) << 8) | ((count % 4) << 6);
        end
        else if (dir) begin
            return count << amount;
        end
        else begin
            return count >> amount;
        end
    endfunction

    task automatic expect_word(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Mismatch at %0t: %s = %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic report_error(input string what);
        error_count++;
        $display("Error at %0t: %s", $time, what);
    endtask

    task automatic wait_for_ready(input logic level, input int limit);
        int cycles;
        cycles = 0;
        while (ready !== level && cycles < limit) begin
            @(negedge ap_clk);
            cycles++;
        end
        if (ready !== level) begin
            report_error($sformatf("ready did not go to %0b within %0d cycles", level, limit));
        end
    endtask

    // --------------------
    // Drive one run, pop, compare and release
    // --------------------
    task automatic run_requests(input logic [31:0] pointer, input logic [31:0] first,
                                input logic [31:0] last, input logic [31:0] stride,
                                input logic dir, input logic [4:0] amount, input logic flush,
                                input int hold_cycles, input logic random_gaps);
        logic [31:0] exp_q [$];
        logic [31:0] r;
        longint      c;
        int          rx;
        int          cycles;
        c = first;
        while (c < last) begin
            exp_q.push_back(32'(c));
            c = c + stride;
        end
        @(negedge ap_clk);
        cfg_array_pointer = pointer;
        cfg_start_read    = first;
        cfg_end_read      = last;
        cfg_stride        = stride;
        cfg_shift_dir     = dir;
        cfg_shift_amount  = amount;
        cfg_flush_mode    = flush;
        cfg_valid         = 1'b1;
        start             = 1'b1;
        wait_for_ready(1'b0, START_LATENCY);
        rx     = 0;
        cycles = 0;
        while (!done && cycles < TIMEOUT_CYCLES) begin
            @(negedge ap_clk);
            if (request_valid) begin
                if (rx < exp_q.size()) begin
                    expect_word($sformatf("request_base[%0d]", rx), request_base, pointer);
                    expect_word($sformatf("request_offset[%0d]", rx), request_offset,
                                expected_offset(exp_q[rx], flush, dir, amount));
                    expect_word($sformatf("request_data[%0d]", rx), request_data, exp_q[rx]);
                end
                else begin
                    report_error("request arrived beyond the end of the range");
                end
                rx++;
            end
            r = random_gaps ? xorshift32() : 32'hffff_ffff;
            request_pop = (cycles >= hold_cycles) && (r[1:0] != 2'b00);
            cycles++;
        end
        if (!done) begin
            report_error("timed out waiting for done");
        end
        else if (rx < exp_q.size()) begin
            report_error("done rose before the last request arrived");
        end
        expect_word("request count", 32'(rx), 32'(exp_q.size()));
        request_pop = 1'b0;
        start       = 1'b0;
        cfg_valid   = 1'b0;
        wait_for_ready(1'b1, READY_TIMEOUT);
        expect_word("done in idle", 32'(done), 32'd1);
    endtask

    // --------------------
    // Directed tests
    // --------------------
    task automatic test_reset_state();
        $display("Test: reset state");
        repeat (8) begin
            @(negedge ap_clk);
            expect_word("ready", 32'(ready), 32'd0);
            expect_word("done", 32'(done), 32'd0);
            expect_word("request_valid", 32'(request_valid), 32'd0);
        end
        areset_engine = 1'b0;
        wait_for_ready(1'b1, READY_TIMEOUT);
        expect_word("done after reset", 32'(done), 32'd1);
    endtask

    task automatic test_left_shift();
        $display("Test: left shift run");
        run_requests(32'h1000_0000, 32'd0, 32'd10, 32'd1, 1'b1, 5'd2, 1'b0, 0, 1'b0);
    endtask

    task automatic test_right_shift_stride();
        $display("Test: right shift run with stride");
        run_requests(32'h2000_0000, 32'd64, 32'd200, 32'd8, 1'b0, 5'd3, 1'b0, 0, 1'b0);
    endtask

    task automatic test_flush_mode();
        $display("Test: flush mode");
        run_requests(32'h2400_0000, 32'd3, 32'd11, 32'd1, 1'b0, 5'd0, 1'b1, 0, 1'b1);
    endtask

    task automatic test_back_pressure();
        $display("Test: back-pressure");
        run_requests(32'h3000_0000, 32'd0, 32'd40, 32'd1, 1'b1, 5'd3, 1'b0, 100, 1'b1);
    endtask

    task automatic test_empty_and_restart();
        logic [31:0] r;
        logic [31:0] first;
        $display("Test: empty range and restart");
        run_requests(32'h4000_0000, 32'd100, 32'd100, 32'd4, 1'b1, 5'd0, 1'b0, 0, 1'b0);
        r     = xorshift32();
        first = {27'd0, r[4:0]};
        run_requests(32'h5000_0000, first, first + 32'd30 + {28'd0, r[11:8]},
                     {29'd0, r[14:12]} + 32'd1, r[15], {2'd0, r[18:16]}, 1'b0, 0, 1'b1);
    endtask

    initial begin
        ap_clk            = 1'b0;
        areset_engine     = 1'b1;
        start             = 1'b0;
        cfg_valid         = 1'b0;
        cfg_array_pointer = '0;
        cfg_start_read    = '0;
        cfg_end_read      = '0;
        cfg_stride        = '0;
        cfg_shift_dir     = 1'b0;
        cfg_shift_amount  = '0;
        cfg_flush_mode    = 1'b0;
        request_pop       = 1'b0;
        error_count       = 0;
        check_count       = 0;
        rng_state         = 32'd42;

        test_reset_state();
        test_left_shift();
        test_right_shift_stride();
        test_flush_mode();
        test_back_pressure();
        test_empty_and_restart();

        repeat (4) @(negedge ap_clk);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end
        else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
